/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_core_slice
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/pipe_reg.sv
rtl/ex_stage.sv
rtl/core_slice.sv
testbench/tb_core_slice.sv

/* rtl/core_slice.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module core_slice (
    input  logic                clk,
    input  logic                rst,
    input  logic                kill,
    input  logic                inst_valid,
    input  logic [31:0]         inst_pc,
    input  logic [31:0]         inst_word,
    output logic                inst_ready,
    output logic                wb_valid,
    output rv_pipe_pkg::ex_wb_t wb_data,
    input  logic                wb_ready
);

    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic                  rf_w_en;

    logic                  id_valid;
    logic                  id_ready;
    rv_pipe_pkg::id_ex_t   id_data;
    logic                  exq_valid;
    logic                  exq_ready;
    rv_pipe_pkg::id_ex_t   exq_data;
    logic                  ex_valid;
    logic                  ex_ready;
    rv_pipe_pkg::ex_wb_t   ex_data;

    // write lands on the same edge the result leaves.
    assign rf_w_en = wb_valid && wb_ready && wb_data.rd_w_en;

    regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .w_en     (rf_w_en),
        .w_addr   (wb_data.rd),
        .w_data   (wb_data.result)
    );

    id_stage i_id_stage (
        .in_valid  (inst_valid),
        .in_ready  (inst_ready),
        .in_pc     (inst_pc),
        .in_inst   (inst_word),
        .kill      (kill),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .exq_valid (exq_valid),
        .exq       (exq_data),
        .wbq_valid (wb_valid),
        .wbq       (wb_data),
        .out_valid (id_valid),
        .out       (id_data),
        .out_ready (id_ready)
    );

    pipe_reg #(.payload_t(rv_pipe_pkg::id_ex_t)) i_id_ex (
        .clk       (clk),
        .rst       (rst),
        .flush     (kill),
        .in_valid  (id_valid),
        .in_ready  (id_ready),
        .in_data   (id_data),
        .out_valid (exq_valid),
        .out_data  (exq_data),
        .out_ready (exq_ready)
    );

    ex_stage i_ex_stage (
        .in_valid  (exq_valid),
        .in_ready  (exq_ready),
        .in_data   (exq_data),
        .out_valid (ex_valid),
        .out_data  (ex_data),
        .out_ready (ex_ready)
    );

    pipe_reg #(.payload_t(rv_pipe_pkg::ex_wb_t)) i_ex_wb (
        .clk       (clk),
        .rst       (rst),
        .flush     (kill),
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_data   (ex_data),
        .out_valid (wb_valid),
        .out_data  (wb_data),
        .out_ready (wb_ready)
    );

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module ex_stage (
    input  logic                in_valid,
    output logic                in_ready,
    input  rv_pipe_pkg::id_ex_t in_data,
    output logic                out_valid,
    output rv_pipe_pkg::ex_wb_t out_data,
    input  logic                out_ready
);

    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] a_zext_w;
    logic [`RV_XLEN-1:0] a_sext_w;
    logic [`RV_XLEN-1:0] res;
    logic [5:0]          shamt;

    assign a = in_data.src1;
    assign b = in_data.src2;

    // word shifts see the low word and a 5-bit amount.
    assign a_zext_w = {32'b0, a[31:0]};
    assign a_sext_w = {{32{a[31]}}, a[31:0]};
    assign shamt    = in_data.word_op ? {1'b0, b[4:0]} : b[5:0];

    always_comb begin
        case (in_data.alu_op)
            rv_isa_pkg::ADD:  res = a + b;
            rv_isa_pkg::SUB:  res = a - b;
            rv_isa_pkg::SLL:  res = a << shamt;
            rv_isa_pkg::SLT:  res = {63'b0, ($signed(a) < $signed(b))};
            rv_isa_pkg::SLTU: res = {63'b0, (a < b)};
            rv_isa_pkg::XOR:  res = a ^ b;
            rv_isa_pkg::SRL:  res = (in_data.word_op ? a_zext_w : a) >> shamt;
            rv_isa_pkg::SRA:  res = $signed(in_data.word_op ? a_sext_w : a) >>> shamt;
            rv_isa_pkg::OR:   res = a | b;
            rv_isa_pkg::AND:  res = a & b;
            default:          res = b;
        endcase
    end

    // single-cycle execute.
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    always_comb begin
        out_data.pc      = in_data.pc;
        out_data.rd      = in_data.rd;
        out_data.rd_w_en = in_data.rd_w_en && !in_data.illegal;
        if (in_data.word_op) begin
            out_data.result = {{32{res[31]}}, res[31:0]};
        end else begin
            out_data.result = res;
        end
        out_data.illegal = in_data.illegal;
    end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module id_stage (
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_pc,
    input  logic [31:0]           in_inst,
    input  logic                  kill,
    output logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  exq_valid,
    input  rv_pipe_pkg::id_ex_t   exq,
    input  logic                  wbq_valid,
    input  rv_pipe_pkg::ex_wb_t   wbq,
    output logic                  out_valid,
    output rv_pipe_pkg::id_ex_t   out,
    input  logic                  out_ready
);

    rv_isa_pkg::opcode_e   opcode;
    rv_isa_pkg::alu_op_e   alu_op;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_u;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  is_reg;
    logic                  word_op;
    logic                  illegal;
    logic                  ex_hit;
    logic                  wb_hit;
    logic                  hazard;
    logic                  go;

    assign opcode   = rv_isa_pkg::opcode_e'(in_inst[6:0]);
    assign rd       = in_inst[11:7];
    assign funct3   = in_inst[14:12];
    assign rs1_addr = in_inst[19:15];
    assign rs2_addr = in_inst[24:20];

    assign imm_i = {{52{in_inst[31]}}, in_inst[31:20]};
    assign imm_u = {{32{in_inst[31]}}, in_inst[31:12], 12'b0};

    // instruction group.
    always_comb begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        is_reg  = 1'b0;
        word_op = 1'b0;
        illegal = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                is_reg  = 1'b1;
                use_rs2 = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
            end
            rv_isa_pkg::OP_32: begin
                is_reg  = 1'b1;
                use_rs2 = 1'b1;
                word_op = 1'b1;
            end
            rv_isa_pkg::OP_IMM_32: begin
                word_op = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                use_rs1 = 1'b0;
            end
            default: begin
                use_rs1 = 1'b0;
                illegal = 1'b1;
            end
        endcase
    end

    // bit 30 selects sub and sra, in the immediate forms too for srai.
    always_comb begin
        alu_op = rv_isa_pkg::ADD;
        case (funct3)
            3'b000: alu_op = (is_reg && in_inst[30]) ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            3'b001: alu_op = rv_isa_pkg::SLL;
            3'b010: alu_op = rv_isa_pkg::SLT;
            3'b011: alu_op = rv_isa_pkg::SLTU;
            3'b100: alu_op = rv_isa_pkg::XOR;
            3'b101: alu_op = in_inst[30] ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
            3'b110: alu_op = rv_isa_pkg::OR;
            default: alu_op = rv_isa_pkg::AND;
        endcase
        if (opcode == rv_isa_pkg::LUI) begin
            alu_op = rv_isa_pkg::PASS_B;
        end
    end

    // raw hazard against both stage registers.
    assign ex_hit = exq_valid && exq.rd_w_en && (exq.rd != '0);
    assign wb_hit = wbq_valid && wbq.rd_w_en && (wbq.rd != '0);

    assign hazard = (use_rs1 && ((ex_hit && (exq.rd == rs1_addr)) ||
                                 (wb_hit && (wbq.rd == rs1_addr)))) ||
                    (use_rs2 && ((ex_hit && (exq.rd == rs2_addr)) ||
                                 (wb_hit && (wbq.rd == rs2_addr))));

    assign go        = !hazard && !kill;
    assign out_valid = in_valid && go;
    assign in_ready  = out_ready && go;

    always_comb begin
        out.pc      = in_pc;
        out.inst    = in_inst;
        out.rd      = rd;
        out.rd_w_en = (rd != '0);
        out.alu_op  = alu_op;
        out.src1    = rs1_data;
        if (use_rs2) begin
            out.src2 = rs2_data;
        end else if (opcode == rv_isa_pkg::LUI) begin
            out.src2 = imm_u;
        end else begin
            out.src2 = imm_i;
        end
        out.word_op = word_op;
        out.illegal = illegal;
    end

endmodule

`default_nettype wire

/* rtl/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic load;

    // free when empty or when the held entry leaves this cycle.
    assign in_ready = out_ready || !out_valid;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // data stays put on a bubble, only valid drops.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_data <= '0;
        end else if (load) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  w_en,
    input  logic [`RV_REG_AW-1:0] w_addr,
    input  logic [`RV_XLEN-1:0]   w_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && (w_addr != '0)) begin
            regs[w_addr] <= w_data;
        end
    end

    // x0 reads as zero.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes handled by the slice.
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111
    } opcode_e;

    // alu operations, pass_b forwards the second operand.
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

/* rtl/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// integer register width.
`define RV_XLEN 64

// number of architectural registers.
`define RV_NREGS 32

// register index width.
`define RV_REG_AW 5

`endif

/* rtl/rv_pipe_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package rv_pipe_pkg;

    // decoded instruction between decode and execute.
    typedef struct packed {
        logic [31:0]           pc;
        logic [31:0]           inst;
        logic [`RV_REG_AW-1:0] rd;
        logic                  rd_w_en;
        rv_isa_pkg::alu_op_e   alu_op;
        logic [`RV_XLEN-1:0]   src1;
        logic [`RV_XLEN-1:0]   src2;
        logic                  word_op;
        logic                  illegal;
    } id_ex_t;

    // retiring result between execute and writeback.
    typedef struct packed {
        logic [31:0]           pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  rd_w_en;
        logic [`RV_XLEN-1:0]   result;
        logic                  illegal;
    } ex_wb_t;

endpackage

`default_nettype wire

/* testbench/tb_core_slice.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module tb_core_slice;

    // alu rows are add sub slt sltu xor or and sll srl sra.
    localparam logic [2:0] ALU_F3 [10] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4,
                                           3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    localparam logic [9:0] ALU_ALT = 10'b10_0000_0010;
    // word rows are addw subw sllw srlw sraw.
    localparam logic [2:0] WORD_F3 [5] = '{3'd0, 3'd0, 3'd1, 3'd5, 3'd5};
    localparam logic [4:0] WORD_ALT = 5'b10010;

    logic                clk;
    logic                rst;
    logic                kill;
    logic                inst_valid;
    logic [31:0]         inst_pc;
    logic [31:0]         inst_word;
    logic                inst_ready;
    logic                wb_valid;
    rv_pipe_pkg::ex_wb_t wb_data;
    logic                wb_ready;

    logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];
    rv_pipe_pkg::ex_wb_t exp_q [$];
    logic [15:0]         lfsr = 16'd7;
    logic [31:0]         pc;

    core_slice i_core_slice (
        .clk        (clk),
        .rst        (rst),
        .kill       (kill),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_word  (inst_word),
        .inst_ready (inst_ready),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_ready   (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // result is a don't care for an illegal instruction.
    task automatic check_wb(input rv_pipe_pkg::ex_wb_t got, input rv_pipe_pkg::ex_wb_t exp);
        if (got.pc !== exp.pc || got.rd !== exp.rd || got.rd_w_en !== exp.rd_w_en ||
            got.illegal !== exp.illegal || (!exp.illegal && got.result !== exp.result)) begin
            $display("FAILED at %0t: wb_data got pc=%h rd=%0d w_en=%b result=%h illegal=%b",
                     $time, got.pc, got.rd, got.rd_w_en, got.result, got.illegal);
            $display("  expected pc=%h rd=%0d w_en=%b result=%h illegal=%b",
                     exp.pc, exp.rd, exp.rd_w_en, exp.result, exp.illegal);
            stop_run();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic bit is_legal(input logic [6:0] opc);
        return opc == rv_isa_pkg::OP || opc == rv_isa_pkg::OP_IMM || opc == rv_isa_pkg::LUI ||
               opc == rv_isa_pkg::OP_32 || opc == rv_isa_pkg::OP_IMM_32;
    endfunction

    // reference result from the rv64i definitions.
    function automatic logic [63:0] model_result(input logic [31:0] inst);
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] w;
        logic [6:0]  opc;
        logic        alt;
        opc = inst[6:0];
        alt = inst[30];
        a = model_regs[inst[19:15]];
        b = {{52{inst[31]}}, inst[31:20]};
        if (opc == rv_isa_pkg::OP || opc == rv_isa_pkg::OP_32) begin
            b = model_regs[inst[24:20]];
        end
        if (opc == rv_isa_pkg::LUI) begin
            return {{32{inst[31]}}, inst[31:12], 12'h000};
        end
        if (opc == rv_isa_pkg::OP_32 || opc == rv_isa_pkg::OP_IMM_32) begin
            if (inst[14:12] == 3'd1) begin
                w = a[31:0] << b[4:0];
            end else if (inst[14:12] == 3'd5 && alt) begin
                w = $signed(a[31:0]) >>> b[4:0];
            end else if (inst[14:12] == 3'd5) begin
                w = a[31:0] >> b[4:0];
            end else if (alt && opc == rv_isa_pkg::OP_32) begin
                w = a[31:0] - b[31:0];
            end else begin
                w = a[31:0] + b[31:0];
            end
            return {{32{w[31]}}, w};
        end
        case (inst[14:12])
            3'd0: return (alt && opc == rv_isa_pkg::OP) ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // drives one instruction and waits for the fetch handshake.
    task automatic issue(input logic [31:0] inst, input bit tracked);
        rv_pipe_pkg::ex_wb_t e;
        int                  n;
        logic                taken;
        if (tracked) begin
            e.pc      = pc;
            e.rd      = inst[11:7];
            e.illegal = !is_legal(inst[6:0]);
            e.rd_w_en = !e.illegal && (inst[11:7] != 5'd0);
            e.result  = e.illegal ? '0 : model_result(inst);
            if (e.rd_w_en) begin
                model_regs[e.rd] = e.result;
            end
            exp_q.push_back(e);
        end
        inst_valid = 1'b1;
        inst_word  = inst;
        inst_pc    = pc;
        n          = 0;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = inst_ready;
            @(posedge clk);
            #1;
            n++;
            if (!taken && n == 60) begin
                give_up("inst_ready");
            end
        end
        inst_valid = 1'b0;
        pc += 4;
    endtask

    task automatic copy_reg(input logic [4:0] r);
        issue(enc_i(12'd0, r, 3'd0, 5'd31, rv_isa_pkg::OP_IMM), 1'b1);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n == 100) begin
                give_up("outstanding writebacks");
            end
        end
    endtask

    // every retirement is matched against the oldest prediction.
    always @(negedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("writeback at %0t with no instruction outstanding", $time);
                stop_run();
            end else begin
                check_wb(wb_data, exp_q.pop_front());
            end
        end
    end

    task automatic test_reset();
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("wb_data.rd_w_en", wb_data.rd_w_en, 1'b0);
        check_bit("inst_ready", inst_ready, 1'b1);
    endtask

    task automatic test_alu();
        logic [4:0] rd;
        for (int r = 1; r <= 8; r++) begin
            issue(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'(r), rv_isa_pkg::OP_IMM), 1'b1);
        end
        for (int k = 0; k < 10; k++) begin
            rd = 5'd9 + 5'(rand_bits(4));
            issue(enc_r(ALU_ALT[k], 5'd1 + 5'(rand_bits(3)), 5'd1 + 5'(rand_bits(3)),
                        ALU_F3[k], rd, rv_isa_pkg::OP), 1'b1);
            copy_reg(rd);
        end
        drain();
    endtask

    task automatic test_word();
        logic [4:0] rd;
        // spread the operands above bit 31.
        for (int r = 1; r <= 8; r++) begin
            issue(enc_i(12'd28, 5'(r), 3'd1, 5'(r), rv_isa_pkg::OP_IMM), 1'b1);
            issue(enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), rv_isa_pkg::OP_IMM), 1'b1);
        end
        for (int k = 0; k < 5; k++) begin
            rd = 5'd9 + 5'(rand_bits(4));
            issue(enc_r(WORD_ALT[k], 5'd1 + 5'(rand_bits(3)), 5'd1 + 5'(rand_bits(3)),
                        WORD_F3[k], rd, rv_isa_pkg::OP_32), 1'b1);
            copy_reg(rd);
        end
        // top bit set so the upper word must fill with ones.
        issue({1'b1, 19'(rand_bits(19)), 5'd12, 7'(rv_isa_pkg::LUI)}, 1'b1);
        copy_reg(5'd12);
        drain();
    endtask

    task automatic test_chain();
        logic [4:0] prev;
        logic [4:0] rd;
        prev = 5'd1;
        for (int k = 0; k < 6; k++) begin
            rd = 5'd9 + 5'(rand_bits(4));
            if (k % 2 == 0) begin
                issue(enc_i(12'(rand_bits(12)), prev, 3'd0, rd, rv_isa_pkg::OP_IMM), 1'b1);
            end else begin
                issue(enc_r(1'b0, prev, 5'd1, 3'd0, rd, rv_isa_pkg::OP), 1'b1);
            end
            prev = rd;
        end
        drain();
    endtask

    task automatic test_backpressure();
        rv_pipe_pkg::ex_wb_t held;
        logic [11:0]         imm [3];
        int                  hold;
        int                  n;
        for (int k = 0; k < 3; k++) begin
            imm[k] = 12'(rand_bits(12));
        end
        hold = 2 + int'(rand_bits(3));
        wb_ready = 1'b0;
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    issue(enc_i(imm[k], 5'd0, 3'd0, 5'(20 + k), rv_isa_pkg::OP_IMM), 1'b1);
                end
            end
            begin
                n = 0;
                do begin
                    @(negedge clk);
                    n++;
                    if (n == 20 && !wb_valid) begin
                        give_up("wb_valid under back-pressure");
                    end
                end while (!wb_valid);
                held = wb_data;
                repeat (hold) begin
                    @(negedge clk);
                    check_bit("inst_ready", inst_ready, 1'b0);
                    check_bit("wb_valid", wb_valid, 1'b1);
                    check_wb(wb_data, held);
                end
                @(posedge clk);
                #1;
                wb_ready = 1'b1;
            end
        join
        drain();
    endtask

    task automatic test_kill_illegal();
        wb_ready = 1'b0;
        issue(enc_i(12'h123, 5'd0, 3'd0, 5'd23, rv_isa_pkg::OP_IMM), 1'b0);
        issue(enc_i(12'h456, 5'd0, 3'd0, 5'd24, rv_isa_pkg::OP_IMM), 1'b0);
        check_bit("wb_valid", wb_valid, 1'b1);
        kill = 1'b1;
        @(posedge clk);
        #1;
        // pipe is empty here, so only kill can hold inst_ready low.
        @(negedge clk);
        check_bit("inst_ready", inst_ready, 1'b0);
        check_bit("wb_valid", wb_valid, 1'b0);
        @(posedge clk);
        #1;
        kill     = 1'b0;
        wb_ready = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("wb_valid", wb_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        copy_reg(5'd23);
        copy_reg(5'd24);
        // load opcode is outside the slice.
        issue(enc_i(12'(rand_bits(12)), 5'd2, 3'd3, 5'd9, 7'b0000011), 1'b1);
        copy_reg(5'd9);
        drain();
    endtask

    initial begin
        rst        = 1'b1;
        kill       = 1'b0;
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_word  = '0;
        wb_ready   = 1'b1;
        pc         = 32'h0000_1000;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_alu();
        test_word();
        test_chain();
        test_backpressure();
        test_kill_illegal();
        if (exp_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d instructions never retired", exp_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire
